/* common/decoder_stage_pkg.sv */
`default_nettype none

package decoder_stage_pkg;

    localparam int STAGE_WIDTH = 2;

    // Held as a level by the external controller
    typedef enum logic [STAGE_WIDTH-1:0] {
        STAGE_IDLE                = 2'd0,
        STAGE_MEASUREMENT_LOADING = 2'd1,
        STAGE_GROW                = 2'd2,
        STAGE_MERGE               = 2'd3
    } decoder_stage_t;

endpackage

`default_nettype wire

/* common/graph_geometry_pkg.sv */
`default_nettype none

package graph_geometry_pkg;

    localparam int GRID_WIDTH_X = 3;    // Rows
    localparam int GRID_WIDTH_Z = 3;    // Columns
    localparam int GRID_WIDTH_U = 3;    // Measurement rounds

    localparam int X_BIT_WIDTH = $clog2(GRID_WIDTH_X);
    localparam int Z_BIT_WIDTH = $clog2(GRID_WIDTH_Z);
    localparam int U_BIT_WIDTH = $clog2(GRID_WIDTH_U);
    localparam int ADDRESS_WIDTH = U_BIT_WIDTH + X_BIT_WIDTH + Z_BIT_WIDTH;

    localparam int PU_COUNT_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT = PU_COUNT_PER_ROUND * GRID_WIDTH_U;

    // One interface slot per unit boundary along each axis, grid edges included
    localparam int NS_SLOT_COUNT = GRID_WIDTH_U * (GRID_WIDTH_X + 1) * GRID_WIDTH_Z;
    localparam int EW_SLOT_COUNT = GRID_WIDTH_U * GRID_WIDTH_X * (GRID_WIDTH_Z + 1);
    localparam int UD_SLOT_COUNT = (GRID_WIDTH_U + 1) * GRID_WIDTH_X * GRID_WIDTH_Z;

    localparam int NEIGHBOR_COUNT = 6;
    localparam int NEIGHBOR_NORTH = 0;  // Row - 1
    localparam int NEIGHBOR_SOUTH = 1;  // Row + 1
    localparam int NEIGHBOR_WEST  = 2;  // Column - 1
    localparam int NEIGHBOR_EAST  = 3;  // Column + 1
    localparam int NEIGHBOR_DOWN  = 4;  // Older round
    localparam int NEIGHBOR_UP    = 5;  // Newer round

    localparam int LINK_BIT_WIDTH = 2;

    typedef logic [ADDRESS_WIDTH-1:0] pu_address_t;     // {round, row, column}
    typedef logic [LINK_BIT_WIDTH-1:0] link_count_t;

    localparam link_count_t LINK_WEIGHT = 2'd2;         // Same for every link

endpackage

`default_nettype wire

/* common/neighbor_link_if.sv */
`default_nettype none

// Side a is always the unit with the lower coordinate along the link axis
interface neighbor_link_if;

    logic                            a_increase;     // Reached flag of side a
    logic                            b_increase;     // Reached flag of side b
    logic                            fully_grown;
    graph_geometry_pkg::pu_address_t a_root;
    graph_geometry_pkg::pu_address_t b_root;

    modport side_a (
        output a_increase,
        output a_root,
        input  b_increase,  // Needed for reach spreading
        input  fully_grown,
        input  b_root
    );

    modport side_b (
        output b_increase,
        output b_root,
        input  a_increase,
        input  fully_grown,
        input  a_root
    );

    modport link (
        input  a_increase,
        input  b_increase,
        output fully_grown
    );

endinterface

`default_nettype wire

/* flist.f */
+incdir+testbench
common/graph_geometry_pkg.sv
common/decoder_stage_pkg.sv
common/neighbor_link_if.sv
rtl/neighbor_link.sv
rtl/processing_unit.sv
rtl/decoding_graph.sv
testbench/tb_clock_gen.sv
testbench/tb_decoding_graph.sv

/* rtl/decoding_graph.sv */
`default_nettype none

module decoding_graph (
    input  logic                                                       clk,
    input  logic                                                       rst_n_i,
    input  logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0]          measurements_i,
    input  logic [decoder_stage_pkg::STAGE_WIDTH-1:0]                  global_stage_i,
    output graph_geometry_pkg::pu_address_t [graph_geometry_pkg::PU_COUNT-1:0] roots_o,
    output logic [graph_geometry_pkg::PU_COUNT-1:0]                    busy_o
);

    decoder_stage_pkg::decoder_stage_t        stage;
    logic [graph_geometry_pkg::PU_COUNT-1:0]  unit_measurement;   // Into each unit
    logic [graph_geometry_pkg::PU_COUNT-1:0]  measurement_chain;  // Out of each unit

    neighbor_link_if ns_if [graph_geometry_pkg::NS_SLOT_COUNT] ();
    neighbor_link_if ew_if [graph_geometry_pkg::EW_SLOT_COUNT] ();
    neighbor_link_if ud_if [graph_geometry_pkg::UD_SLOT_COUNT] ();

    // Output packing order, round * 9 + row * 3 + column
    function automatic int pu_index(input int k, input int i, input int j);
        return (k * graph_geometry_pkg::GRID_WIDTH_X + i) * graph_geometry_pkg::GRID_WIDTH_Z + j;
    endfunction

    function automatic graph_geometry_pkg::pu_address_t pu_address(input int k, input int i,
                                                                   input int j);
        return graph_geometry_pkg::pu_address_t'(
            (k << (graph_geometry_pkg::X_BIT_WIDTH + graph_geometry_pkg::Z_BIT_WIDTH)) |
            (i << graph_geometry_pkg::Z_BIT_WIDTH) | j);
    endfunction

    // Slot i sits above row i
    function automatic int ns_slot(input int k, input int i, input int j);
        return (k * (graph_geometry_pkg::GRID_WIDTH_X + 1) + i) * graph_geometry_pkg::GRID_WIDTH_Z
               + j;
    endfunction

    // Slot j sits left of column j
    function automatic int ew_slot(input int k, input int i, input int j);
        return (k * graph_geometry_pkg::GRID_WIDTH_X + i) * (graph_geometry_pkg::GRID_WIDTH_Z + 1)
               + j;
    endfunction

    // Slot k sits below round k
    function automatic int ud_slot(input int k, input int i, input int j);
        return (k * graph_geometry_pkg::GRID_WIDTH_X + i) * graph_geometry_pkg::GRID_WIDTH_Z + j;
    endfunction

    assign stage = decoder_stage_pkg::decoder_stage_t'(global_stage_i);

    for (genvar k = 0; k < graph_geometry_pkg::GRID_WIDTH_U; k++) begin : pu_k
        for (genvar i = 0; i < graph_geometry_pkg::GRID_WIDTH_X; i++) begin : pu_i
            for (genvar j = 0; j < graph_geometry_pkg::GRID_WIDTH_Z; j++) begin : pu_j
                if (k == graph_geometry_pkg::GRID_WIDTH_U - 1) begin : top_layer
                    assign unit_measurement[pu_index(k, i, j)] =
                        measurements_i[i * graph_geometry_pkg::GRID_WIDTH_Z + j];
                end else begin : lower_layer
                    assign unit_measurement[pu_index(k, i, j)] =
                        measurement_chain[pu_index(k + 1, i, j)];   // Shift down one round
                end

                processing_unit #(
                    .ADDRESS (pu_address(k, i, j))
                ) u_pu (
                    .clk            (clk),
                    .rst_n_i        (rst_n_i),
                    .global_stage_i (stage),
                    .measurement_i  (unit_measurement[pu_index(k, i, j)]),
                    .measurement_o  (measurement_chain[pu_index(k, i, j)]),
                    .north_port     (ns_if[ns_slot(k, i, j)]),
                    .south_port     (ns_if[ns_slot(k, i + 1, j)]),
                    .west_port      (ew_if[ew_slot(k, i, j)]),
                    .east_port      (ew_if[ew_slot(k, i, j + 1)]),
                    .down_port      (ud_if[ud_slot(k, i, j)]),
                    .up_port        (ud_if[ud_slot(k + 1, i, j)]),
                    .root_o         (roots_o[pu_index(k, i, j)]),
                    .busy_o         (busy_o[pu_index(k, i, j)])
                );
            end
        end
    end

    // Grid edges have no link, the absent side never wins a minimum
    for (genvar k = 0; k < graph_geometry_pkg::GRID_WIDTH_U; k++) begin : ns_k
        for (genvar i = 0; i <= graph_geometry_pkg::GRID_WIDTH_X; i++) begin : ns_i
            for (genvar j = 0; j < graph_geometry_pkg::GRID_WIDTH_Z; j++) begin : ns_j
                if (i == 0) begin : edge_north
                    assign ns_if[ns_slot(k, i, j)].fully_grown = 1'b0;
                    assign ns_if[ns_slot(k, i, j)].a_increase  = 1'b0;
                    assign ns_if[ns_slot(k, i, j)].a_root      = '1;
                end else if (i == graph_geometry_pkg::GRID_WIDTH_X) begin : edge_south
                    assign ns_if[ns_slot(k, i, j)].fully_grown = 1'b0;
                    assign ns_if[ns_slot(k, i, j)].b_increase  = 1'b0;
                    assign ns_if[ns_slot(k, i, j)].b_root      = '1;
                end else begin : internal
                    neighbor_link u_link (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .global_stage_i (stage),
                        .link_port      (ns_if[ns_slot(k, i, j)])
                    );
                end
            end
        end
    end

    for (genvar k = 0; k < graph_geometry_pkg::GRID_WIDTH_U; k++) begin : ew_k
        for (genvar i = 0; i < graph_geometry_pkg::GRID_WIDTH_X; i++) begin : ew_i
            for (genvar j = 0; j <= graph_geometry_pkg::GRID_WIDTH_Z; j++) begin : ew_j
                if (j == 0) begin : edge_west
                    assign ew_if[ew_slot(k, i, j)].fully_grown = 1'b0;
                    assign ew_if[ew_slot(k, i, j)].a_increase  = 1'b0;
                    assign ew_if[ew_slot(k, i, j)].a_root      = '1;
                end else if (j == graph_geometry_pkg::GRID_WIDTH_Z) begin : edge_east
                    assign ew_if[ew_slot(k, i, j)].fully_grown = 1'b0;
                    assign ew_if[ew_slot(k, i, j)].b_increase  = 1'b0;
                    assign ew_if[ew_slot(k, i, j)].b_root      = '1;
                end else begin : internal
                    neighbor_link u_link (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .global_stage_i (stage),
                        .link_port      (ew_if[ew_slot(k, i, j)])
                    );
                end
            end
        end
    end

    for (genvar k = 0; k <= graph_geometry_pkg::GRID_WIDTH_U; k++) begin : ud_k
        for (genvar i = 0; i < graph_geometry_pkg::GRID_WIDTH_X; i++) begin : ud_i
            for (genvar j = 0; j < graph_geometry_pkg::GRID_WIDTH_Z; j++) begin : ud_j
                if (k == 0) begin : edge_down
                    assign ud_if[ud_slot(k, i, j)].fully_grown = 1'b0;
                    assign ud_if[ud_slot(k, i, j)].a_increase  = 1'b0;
                    assign ud_if[ud_slot(k, i, j)].a_root      = '1;
                end else if (k == graph_geometry_pkg::GRID_WIDTH_U) begin : edge_up
                    assign ud_if[ud_slot(k, i, j)].fully_grown = 1'b0;
                    assign ud_if[ud_slot(k, i, j)].b_increase  = 1'b0;
                    assign ud_if[ud_slot(k, i, j)].b_root      = '1;
                end else begin : internal
                    neighbor_link u_link (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .global_stage_i (stage),
                        .link_port      (ud_if[ud_slot(k, i, j)])
                    );
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/neighbor_link.sv */
`default_nettype none

module neighbor_link (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  decoder_stage_pkg::decoder_stage_t global_stage_i,
    neighbor_link_if.link                     link_port
);

    graph_geometry_pkg::link_count_t               count_q;
    logic [graph_geometry_pkg::LINK_BIT_WIDTH:0]   count_sum;   // One extra bit before saturation
    graph_geometry_pkg::link_count_t               count_next;

    // Each reached endpoint adds one
    assign count_sum = {1'b0, count_q}
                     + {{graph_geometry_pkg::LINK_BIT_WIDTH{1'b0}}, link_port.a_increase}
                     + {{graph_geometry_pkg::LINK_BIT_WIDTH{1'b0}}, link_port.b_increase};

    always_comb begin
        if (count_sum >= {1'b0, graph_geometry_pkg::LINK_WEIGHT}) begin
            count_next = graph_geometry_pkg::LINK_WEIGHT;
        end else begin
            count_next = count_sum[graph_geometry_pkg::LINK_BIT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else begin
            case (global_stage_i)
                decoder_stage_pkg::STAGE_MEASUREMENT_LOADING: begin
                    count_q <= '0;                  // New decode starts ungrown
                end
                decoder_stage_pkg::STAGE_GROW: begin
                    count_q <= count_next;
                end
                default: begin
                    count_q <= count_q;             // Held in merge and idle
                end
            endcase
        end
    end

    assign link_port.fully_grown = (count_q == graph_geometry_pkg::LINK_WEIGHT);

endmodule

`default_nettype wire

/* rtl/processing_unit.sv */
`default_nettype none

// North, west and down neighbors have the lower coordinate, so this unit is side b there
module processing_unit #(
    parameter graph_geometry_pkg::pu_address_t ADDRESS = '0
) (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  decoder_stage_pkg::decoder_stage_t global_stage_i,
    input  logic                              measurement_i,
    output logic                              measurement_o,
    neighbor_link_if.side_b                   north_port,
    neighbor_link_if.side_a                   south_port,
    neighbor_link_if.side_b                   west_port,
    neighbor_link_if.side_a                   east_port,
    neighbor_link_if.side_b                   down_port,
    neighbor_link_if.side_a                   up_port,
    output graph_geometry_pkg::pu_address_t   root_o,
    output logic                              busy_o
);

    logic                                            measurement_q;   // Syndrome bit
    logic                                            reached_q;
    graph_geometry_pkg::pu_address_t                 root_q;
    logic                                            busy_q;

    logic [graph_geometry_pkg::NEIGHBOR_COUNT-1:0]   nb_fully_grown;
    logic [graph_geometry_pkg::NEIGHBOR_COUNT-1:0]   nb_reached;
    graph_geometry_pkg::pu_address_t                 nb_root [graph_geometry_pkg::NEIGHBOR_COUNT];

    logic                                            reach_next;
    graph_geometry_pkg::pu_address_t                 root_next;

    assign nb_fully_grown[graph_geometry_pkg::NEIGHBOR_NORTH] = north_port.fully_grown;
    assign nb_fully_grown[graph_geometry_pkg::NEIGHBOR_SOUTH] = south_port.fully_grown;
    assign nb_fully_grown[graph_geometry_pkg::NEIGHBOR_WEST]  = west_port.fully_grown;
    assign nb_fully_grown[graph_geometry_pkg::NEIGHBOR_EAST]  = east_port.fully_grown;
    assign nb_fully_grown[graph_geometry_pkg::NEIGHBOR_DOWN]  = down_port.fully_grown;
    assign nb_fully_grown[graph_geometry_pkg::NEIGHBOR_UP]    = up_port.fully_grown;

    assign nb_reached[graph_geometry_pkg::NEIGHBOR_NORTH] = north_port.a_increase;
    assign nb_reached[graph_geometry_pkg::NEIGHBOR_SOUTH] = south_port.b_increase;
    assign nb_reached[graph_geometry_pkg::NEIGHBOR_WEST]  = west_port.a_increase;
    assign nb_reached[graph_geometry_pkg::NEIGHBOR_EAST]  = east_port.b_increase;
    assign nb_reached[graph_geometry_pkg::NEIGHBOR_DOWN]  = down_port.a_increase;
    assign nb_reached[graph_geometry_pkg::NEIGHBOR_UP]    = up_port.b_increase;

    assign nb_root[graph_geometry_pkg::NEIGHBOR_NORTH] = north_port.a_root;
    assign nb_root[graph_geometry_pkg::NEIGHBOR_SOUTH] = south_port.b_root;
    assign nb_root[graph_geometry_pkg::NEIGHBOR_WEST]  = west_port.a_root;
    assign nb_root[graph_geometry_pkg::NEIGHBOR_EAST]  = east_port.b_root;
    assign nb_root[graph_geometry_pkg::NEIGHBOR_DOWN]  = down_port.a_root;
    assign nb_root[graph_geometry_pkg::NEIGHBOR_UP]    = up_port.b_root;

    // The reached flag doubles as the growth request on every link
    assign north_port.b_increase = reached_q;
    assign south_port.a_increase = reached_q;
    assign west_port.b_increase  = reached_q;
    assign east_port.a_increase  = reached_q;
    assign down_port.b_increase  = reached_q;
    assign up_port.a_increase    = reached_q;

    assign north_port.b_root = root_q;
    assign south_port.a_root = root_q;
    assign west_port.b_root  = root_q;
    assign east_port.a_root  = root_q;
    assign down_port.b_root  = root_q;
    assign up_port.a_root    = root_q;

    assign reach_next = measurement_q | (|(nb_fully_grown & nb_reached));

    // Smallest root seen across fully grown links
    always_comb begin
        root_next = root_q;
        for (int n = 0; n < graph_geometry_pkg::NEIGHBOR_COUNT; n++) begin
            if (nb_fully_grown[n] && (nb_root[n] < root_next)) begin
                root_next = nb_root[n];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            measurement_q <= 1'b0;
            reached_q     <= 1'b0;
            root_q        <= ADDRESS;
            busy_q        <= 1'b0;
        end else begin
            case (global_stage_i)
                decoder_stage_pkg::STAGE_MEASUREMENT_LOADING: begin
                    measurement_q <= measurement_i;
                    reached_q     <= measurement_i;     // Old reach is dropped, defects seed it
                    root_q        <= ADDRESS;
                    busy_q        <= 1'b0;
                end
                decoder_stage_pkg::STAGE_GROW: begin
                    reached_q <= reach_next;
                    busy_q    <= 1'b0;
                end
                decoder_stage_pkg::STAGE_MERGE: begin
                    root_q <= root_next;
                    busy_q <= (root_next != root_q);    // Flags a root change
                end
                default: begin
                    busy_q <= 1'b0;
                end
            endcase
        end
    end

    assign measurement_o = measurement_q;
    assign root_o        = root_q;
    assign busy_o        = busy_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the decoding graph testbench with Verilator, runs it and checks the log

set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log
TOP=tb_decoding_graph

verilator --binary --timing \
    -f flist.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "$TOP"

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
cat "$LOG_FILE"

if grep -q "^RESULT: PASS$" "$LOG_FILE"; then
    echo "Simulation passed"
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #(CLOCK_PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;     // Released on a falling edge
    end

endmodule

`default_nettype wire

/* testbench/tb_graph_model.svh */
`ifndef TB_GRAPH_MODEL_SVH
`define TB_GRAPH_MODEL_SVH

    // Every link is kept at both ends, indexed by unit and direction
    localparam int MODEL_WEIGHT = int'(graph_geometry_pkg::LINK_WEIGHT);

    int model_meas    [graph_geometry_pkg::PU_COUNT];
    int model_reached [graph_geometry_pkg::PU_COUNT];
    int model_root    [graph_geometry_pkg::PU_COUNT];
    int model_count   [graph_geometry_pkg::PU_COUNT][graph_geometry_pkg::NEIGHBOR_COUNT];

    // Address is {round, row, column}
    function automatic int unit_address(input int u);
        int k;
        int i;
        int j;
        k = u / graph_geometry_pkg::PU_COUNT_PER_ROUND;
        i = (u / graph_geometry_pkg::GRID_WIDTH_Z) % graph_geometry_pkg::GRID_WIDTH_X;
        j = u % graph_geometry_pkg::GRID_WIDTH_Z;
        return (k << (graph_geometry_pkg::X_BIT_WIDTH + graph_geometry_pkg::Z_BIT_WIDTH))
               | (i << graph_geometry_pkg::Z_BIT_WIDTH) | j;
    endfunction

    // Flat index of the neighbor in direction n, -1 past a grid edge
    function automatic int neighbor_of(input int u, input int n);
        int k;
        int i;
        int j;
        int result;
        k = u / graph_geometry_pkg::PU_COUNT_PER_ROUND;
        i = (u / graph_geometry_pkg::GRID_WIDTH_Z) % graph_geometry_pkg::GRID_WIDTH_X;
        j = u % graph_geometry_pkg::GRID_WIDTH_Z;
        case (n)
            graph_geometry_pkg::NEIGHBOR_NORTH: i = i - 1;
            graph_geometry_pkg::NEIGHBOR_SOUTH: i = i + 1;
            graph_geometry_pkg::NEIGHBOR_WEST:  j = j - 1;
            graph_geometry_pkg::NEIGHBOR_EAST:  j = j + 1;
            graph_geometry_pkg::NEIGHBOR_DOWN:  k = k - 1;
            default:                            k = k + 1;
        endcase
        result = k * graph_geometry_pkg::PU_COUNT_PER_ROUND
                 + i * graph_geometry_pkg::GRID_WIDTH_Z + j;
        if (k < 0 || k >= graph_geometry_pkg::GRID_WIDTH_U
            || i < 0 || i >= graph_geometry_pkg::GRID_WIDTH_X
            || j < 0 || j >= graph_geometry_pkg::GRID_WIDTH_Z) begin
            result = -1;
        end
        return result;
    endfunction

    task automatic model_clear();
        for (int u = 0; u < graph_geometry_pkg::PU_COUNT; u++) begin
            model_meas[u]    = 0;
            model_reached[u] = 0;
            model_root[u]    = unit_address(u);
            for (int n = 0; n < graph_geometry_pkg::NEIGHBOR_COUNT; n++) begin
                model_count[u][n] = 0;
            end
        end
    endtask

    // One loading edge, rounds shift down and the new vector enters the top
    task automatic model_load(input logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] vec);
        int top;
        top = (graph_geometry_pkg::GRID_WIDTH_U - 1) * graph_geometry_pkg::PU_COUNT_PER_ROUND;
        for (int u = 0; u < top; u++) begin
            model_meas[u] = model_meas[u + graph_geometry_pkg::PU_COUNT_PER_ROUND];
        end
        for (int p = 0; p < graph_geometry_pkg::PU_COUNT_PER_ROUND; p++) begin
            model_meas[top + p] = int'(vec[p]);
        end
        for (int u = 0; u < graph_geometry_pkg::PU_COUNT; u++) begin
            model_reached[u] = model_meas[u];
            model_root[u]    = unit_address(u);
            for (int n = 0; n < graph_geometry_pkg::NEIGHBOR_COUNT; n++) begin
                model_count[u][n] = 0;
            end
        end
    endtask

    // One grow edge, all updates use the state from before the edge
    task automatic model_grow_cycle();
        int next_reached [graph_geometry_pkg::PU_COUNT];
        int next_count   [graph_geometry_pkg::PU_COUNT][graph_geometry_pkg::NEIGHBOR_COUNT];
        int v;
        for (int u = 0; u < graph_geometry_pkg::PU_COUNT; u++) begin
            next_reached[u] = model_meas[u];
            for (int n = 0; n < graph_geometry_pkg::NEIGHBOR_COUNT; n++) begin
                v = neighbor_of(u, n);
                next_count[u][n] = 0;
                if (v >= 0) begin
                    if (model_count[u][n] == MODEL_WEIGHT && model_reached[v] != 0) begin
                        next_reached[u] = 1;
                    end
                    next_count[u][n] = model_count[u][n] + model_reached[u] + model_reached[v];
                    if (next_count[u][n] > MODEL_WEIGHT) begin
                        next_count[u][n] = MODEL_WEIGHT;    // Saturates at the weight
                    end
                end
            end
        end
        model_reached = next_reached;
        model_count   = next_count;
    endtask

    task automatic model_merge_cycle(output int changed);
        int next_root [graph_geometry_pkg::PU_COUNT];
        int v;
        changed = 0;
        for (int u = 0; u < graph_geometry_pkg::PU_COUNT; u++) begin
            next_root[u] = model_root[u];
            for (int n = 0; n < graph_geometry_pkg::NEIGHBOR_COUNT; n++) begin
                v = neighbor_of(u, n);
                if (v >= 0 && model_count[u][n] == MODEL_WEIGHT
                    && model_root[v] < next_root[u]) begin
                    next_root[u] = model_root[v];
                end
            end
        end
        for (int u = 0; u < graph_geometry_pkg::PU_COUNT; u++) begin
            if (next_root[u] != model_root[u]) begin
                changed = 1;
            end
            model_root[u] = next_root[u];
        end
    endtask

    // Cycles counts merge edges up to and including the first without a change
    task automatic model_merge(output int cycles);
        int changed;
        cycles  = 0;
        changed = 1;
        while (changed != 0 && cycles <= graph_geometry_pkg::PU_COUNT) begin
            model_merge_cycle(changed);
            cycles++;
        end
    endtask

`endif

/* testbench/tb_decoding_graph.sv */
`default_nettype none

module tb_decoding_graph;

    localparam logic [31:0] SEED        = 32'h987d_94c0;
    localparam int MERGE_LIMIT          = graph_geometry_pkg::PU_COUNT;
    localparam int LOAD_CYCLES          = graph_geometry_pkg::GRID_WIDTH_U;
    localparam int ONE_GROW_RUNS        = 3;
    localparam int BACK_TO_BACK_GROW    = 4;
    localparam int DECODE_FIXED         = LOAD_CYCLES + MERGE_LIMIT;
    localparam int CYCLE_LIMIT          = 16 + 100
                                        + (DECODE_FIXED + 10)
                                        + ONE_GROW_RUNS * (DECODE_FIXED + 1)
                                        + (DECODE_FIXED + 3) + (DECODE_FIXED + 4)
                                        + (DECODE_FIXED + 5) + (DECODE_FIXED + 6)
                                        + (DECODE_FIXED + 12)
                                        + 2 * (DECODE_FIXED + BACK_TO_BACK_GROW);
    localparam int CENTER_BIT           = (graph_geometry_pkg::GRID_WIDTH_X / 2)
                                        * graph_geometry_pkg::GRID_WIDTH_Z
                                        + graph_geometry_pkg::GRID_WIDTH_Z / 2;

    logic                                                        clk;
    logic                                                        rst_n;
    logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0]           measurements;
    decoder_stage_pkg::decoder_stage_t                           stage;
    graph_geometry_pkg::pu_address_t [graph_geometry_pkg::PU_COUNT-1:0] roots;
    logic [graph_geometry_pkg::PU_COUNT-1:0]                     busy;

    integer seed;
    integer first_seed;
    int     cycle_count;
    int     check_count;
    int     error_count;
    int     test_count;
    int     failed_tests;
    int     errors_at_start;
    int     merge_cycles;
    logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] vec_a;
    logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] vec_b;
    logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] vec_c;

    `include "tb_graph_model.svh"

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    decoding_graph DUT (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .measurements_i (measurements),
        .global_stage_i (stage),
        .roots_o        (roots),
        .busy_o         (busy)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s is 0x%0h, expected 0x%0h at time %0t",
                     name, actual, expected, $time);
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        int new_errors;
        new_errors = error_count - errors_at_start;
        test_count++;
        if (new_errors == 0) begin
            $display("Test %0d (%s) passed", test_count, name);
        end else begin
            failed_tests++;
            $display("Test %0d (%s) failed with %0d errors", test_count, name, new_errors);
        end
    endtask

    task automatic draw_vector(output logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] vec);
        logic [31:0] rnd;
        rnd = $random(seed);
        vec = rnd[graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0];
    endtask

    // Full decode from a falling edge, then roots and settle time against the model
    task automatic decode_and_compare(
        input  logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] vec0,
        input  logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] vec1,
        input  logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] vec2,
        input  int grow_cycles,
        output int settle_cycles
    );
        logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] vecs [LOAD_CYCLES];
        int model_cycles;
        bit settled;
        vecs[0] = vec0;
        vecs[1] = vec1;
        vecs[2] = vec2;
        stage = decoder_stage_pkg::STAGE_MEASUREMENT_LOADING;
        for (int r = 0; r < LOAD_CYCLES; r++) begin
            measurements = vecs[r];
            @(negedge clk);
            model_load(vecs[r]);
        end
        stage = decoder_stage_pkg::STAGE_GROW;
        repeat (grow_cycles) begin
            @(negedge clk);
            model_grow_cycle();
        end
        stage = decoder_stage_pkg::STAGE_MERGE;
        settle_cycles = 0;
        settled = 1'b0;
        while (!settled && settle_cycles < MERGE_LIMIT) begin
            @(negedge clk);
            settle_cycles++;
            if (busy == '0) begin
                settled = 1'b1;     // No root moved on the last edge
            end
        end
        stage = decoder_stage_pkg::STAGE_IDLE;
        measurements = '0;
        model_merge(model_cycles);
        if (!settled) begin
            error_count++;
            $display("Merge did not settle, busy_o still high after %0d MERGE cycles",
                     MERGE_LIMIT);
        end else begin
            check_value("busy_o settle cycles", 32'(settle_cycles), 32'(model_cycles));
        end
        for (int u = 0; u < graph_geometry_pkg::PU_COUNT; u++) begin
            check_value($sformatf("roots_o[%0d]", u), 32'(roots[u]), 32'(model_root[u]));
        end
    endtask

    task automatic random_decode(input int grow_cycles);
        logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] v0;
        logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] v1;
        logic [graph_geometry_pkg::PU_COUNT_PER_ROUND-1:0] v2;
        int cycles;
        draw_vector(v0);
        draw_vector(v1);
        draw_vector(v2);
        decode_and_compare(v0, v1, v2, grow_cycles, cycles);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout, the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        measurements    = '0;
        stage           = decoder_stage_pkg::STAGE_IDLE;
        seed            = SEED;
        check_count     = 0;
        error_count     = 0;
        test_count      = 0;
        failed_tests    = 0;
        errors_at_start = 0;
        model_clear();
        @(posedge rst_n);
        @(negedge clk);

        start_test();
        check_value("busy_o", 32'(busy), 32'd0);
        for (int u = 0; u < graph_geometry_pkg::PU_COUNT; u++) begin
            check_value($sformatf("roots_o[%0d]", u), 32'(roots[u]), 32'(unit_address(u)));
        end
        finish_test("after reset");

        start_test();
        decode_and_compare('0, '0, '0, 10, merge_cycles);
        check_value("busy_o settle cycles", 32'(merge_cycles), 32'd1);   // Never raised
        for (int u = 0; u < graph_geometry_pkg::PU_COUNT; u++) begin
            check_value($sformatf("roots_o[%0d]", u), 32'(roots[u]), 32'(unit_address(u)));
        end
        finish_test("all-zero measurements");

        start_test();
        for (int r = 0; r < ONE_GROW_RUNS; r++) begin
            random_decode(1);
        end
        finish_test("random defects, one grow cycle");

        start_test();
        for (int g = 3; g <= 6; g++) begin
            random_decode(g);
        end
        finish_test("random defects, three to six grow cycles");

        start_test();
        draw_vector(vec_a);
        draw_vector(vec_b);
        draw_vector(vec_c);
        vec_b[CENTER_BIT] = 1'b1;   // Second vector lands in the middle round
        decode_and_compare(vec_a, vec_b, vec_c, 12, merge_cycles);
        for (int u = 0; u < graph_geometry_pkg::PU_COUNT; u++) begin
            check_value($sformatf("roots_o[%0d]", u), 32'(roots[u]), 32'd0);
        end
        finish_test("center defect, twelve grow cycles");

        start_test();
        first_seed = seed;
        random_decode(BACK_TO_BACK_GROW);
        seed = ~first_seed;         // Different stream for the second decode
        model_clear();
        random_decode(BACK_TO_BACK_GROW);
        finish_test("back-to-back decodes");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
